/* rtl/mini_mcu_pkg.sv */
// ####################
// memory map, register offsets and sizes
// bus request and response structs
// ####################

package mini_mcu_pkg;

  localparam int unsigned NUM_MASTERS = 2;
  localparam int unsigned MASTER_IDX_W = $clog2(NUM_MASTERS);

  // two RAM banks selected by address bit 10
  localparam int unsigned NUM_RAM_BANKS = 2;
  localparam int unsigned RAM_BANK_WORDS = 256;
  localparam int unsigned RAM_BANK_IDX_W = $clog2(NUM_RAM_BANKS);
  localparam int unsigned RAM_WORD_IDX_W = $clog2(RAM_BANK_WORDS);
  localparam int unsigned RAM_BANK_SEL_BIT = 10;

  localparam logic [31:0] RAM_START_ADDRESS = 32'h0000_0000;
  localparam logic [31:0] RAM_SIZE = 32'(NUM_RAM_BANKS * RAM_BANK_WORDS * 4);
  localparam logic [31:0] AO_START_ADDRESS = 32'h2000_0000;
  localparam logic [31:0] GPIO_START_ADDRESS = 32'h3000_0000;
  localparam logic [31:0] PERIPH_SIZE = 32'h0000_0100;
  localparam int unsigned PERIPH_OFFSET_W = $clog2(PERIPH_SIZE);

  localparam logic [PERIPH_OFFSET_W-1:0] AO_EXIT_VALID_OFFSET = 8'h00;
  localparam logic [PERIPH_OFFSET_W-1:0] AO_EXIT_VALUE_OFFSET = 8'h04;
  localparam logic [PERIPH_OFFSET_W-1:0] AO_BOOT_SELECT_OFFSET = 8'h08;
  localparam logic [PERIPH_OFFSET_W-1:0] AO_SCRATCH_OFFSET = 8'h0C;

  localparam logic [PERIPH_OFFSET_W-1:0] GPIO_IN_OFFSET = 8'h00;
  localparam logic [PERIPH_OFFSET_W-1:0] GPIO_OUT_OFFSET = 8'h04;
  localparam logic [PERIPH_OFFSET_W-1:0] GPIO_EN_OFFSET = 8'h08;

  localparam int unsigned GPIO_WIDTH = 32;

  // returned together with err on unmapped accesses
  localparam logic [31:0] ERR_RDATA = 32'hBADC_AB1E;

  typedef enum logic [1:0] {
    SLAVE_RAM,
    SLAVE_AO,
    SLAVE_GPIO,
    SLAVE_NONE
  } slave_idx_e;

  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic        err;
    logic [31:0] rdata;
  } bus_resp_t;

  // merge write data into a word under byte enables
  function automatic logic [31:0] apply_be(input logic [31:0] old_word,
                                           input logic [31:0] wdata,
                                           input logic [3:0]  be);
    logic [31:0] merged;
    merged = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        merged[8*b+:8] = wdata[8*b+:8];
      end
    end
    return merged;
  endfunction

endpackage

/* rtl/system_bus.sv */
// ####################
// system bus: round-robin arbiter for two masters,
// address decoder and response router
// ####################
`timescale 1ns/100ps

module system_bus
  import mini_mcu_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        arst_n_i,

  input  bus_req_t  [NUM_MASTERS-1:0] master_req_i,
  output bus_resp_t [NUM_MASTERS-1:0] master_resp_o,

  output bus_req_t                    ram_req_o,
  input  bus_resp_t                   ram_resp_i,
  output bus_req_t                    ao_req_o,
  input  bus_resp_t                   ao_resp_i,
  output bus_req_t                    gpio_req_o,
  input  bus_resp_t                   gpio_resp_i
);

  function automatic slave_idx_e decode(input logic [31:0] addr);
    if ((addr & ~(RAM_SIZE - 32'd1)) == RAM_START_ADDRESS) begin
      return SLAVE_RAM;
    end
    if ((addr & ~(PERIPH_SIZE - 32'd1)) == AO_START_ADDRESS) begin
      return SLAVE_AO;
    end
    if ((addr & ~(PERIPH_SIZE - 32'd1)) == GPIO_START_ADDRESS) begin
      return SLAVE_GPIO;
    end
    return SLAVE_NONE;
  endfunction

  logic                    any_req;
  logic [MASTER_IDX_W-1:0] winner;
  logic [MASTER_IDX_W-1:0] last_q;
  bus_req_t                win_req;
  slave_idx_e              target;
  logic                    slave_gnt;
  logic                    accept;

  logic                    rsp_valid_q;
  logic [MASTER_IDX_W-1:0] rsp_master_q;
  slave_idx_e              rsp_target_q;
  bus_resp_t               slave_resp;

  // on a tie the master that did not win last time goes first
  always_comb begin
    any_req = master_req_i[0].req | master_req_i[1].req;
    if (master_req_i[0].req && master_req_i[1].req) begin
      winner = ~last_q;
    end else begin
      winner = MASTER_IDX_W'(master_req_i[1].req);
    end
  end

  always_comb begin
    win_req = master_req_i[winner];
    target  = decode(win_req.addr);

    ram_req_o      = win_req;
    ram_req_o.req  = any_req && (target == SLAVE_RAM);
    ao_req_o       = win_req;
    ao_req_o.req   = any_req && (target == SLAVE_AO);
    gpio_req_o     = win_req;
    gpio_req_o.req = any_req && (target == SLAVE_GPIO);

    case (target)
      SLAVE_RAM:  slave_gnt = ram_resp_i.gnt;
      SLAVE_AO:   slave_gnt = ao_resp_i.gnt;
      SLAVE_GPIO: slave_gnt = gpio_resp_i.gnt;
      // the bus itself answers unmapped addresses
      default:    slave_gnt = 1'b1;
    endcase
    accept = any_req && slave_gnt;
  end

  // remember who gets the response next cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      last_q       <= '0;
      rsp_valid_q  <= 1'b0;
      rsp_master_q <= '0;
      rsp_target_q <= SLAVE_NONE;
    end else begin
      rsp_valid_q <= accept;
      if (accept) begin
        last_q       <= winner;
        rsp_master_q <= winner;
        rsp_target_q <= target;
      end
    end
  end

  always_comb begin
    case (rsp_target_q)
      SLAVE_RAM:  slave_resp = ram_resp_i;
      SLAVE_AO:   slave_resp = ao_resp_i;
      SLAVE_GPIO: slave_resp = gpio_resp_i;
      default: begin
        slave_resp        = '0;
        slave_resp.rvalid = rsp_valid_q;
        slave_resp.err    = 1'b1;
        slave_resp.rdata  = ERR_RDATA;
      end
    endcase

    for (int m = 0; m < NUM_MASTERS; m++) begin
      master_resp_o[m].gnt    = accept && (winner == MASTER_IDX_W'(m));
      master_resp_o[m].rvalid = rsp_valid_q && slave_resp.rvalid &&
                                (rsp_master_q == MASTER_IDX_W'(m));
      master_resp_o[m].err    = slave_resp.err;
      master_resp_o[m].rdata  = slave_resp.rdata;
    end
  end

endmodule

/* rtl/memory_subsystem.sv */
// ####################
// banked RAM with byte enables
// ####################
`timescale 1ns/100ps

module memory_subsystem
  import mini_mcu_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,

  input  bus_req_t  req_i,
  output bus_resp_t resp_o
);

  logic [31:0]               mem_q [NUM_RAM_BANKS][RAM_BANK_WORDS];
  logic [RAM_BANK_IDX_W-1:0] bank;
  logic [RAM_WORD_IDX_W-1:0] word_idx;
  logic [31:0]               rdata_q;
  logic                      rvalid_q;

  assign bank     = req_i.addr[RAM_BANK_SEL_BIT+:RAM_BANK_IDX_W];
  assign word_idx = req_i.addr[2+:RAM_WORD_IDX_W];

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      if (req_i.we) begin
        for (int b = 0; b < 4; b++) begin
          if (req_i.be[b]) begin
            mem_q[bank][word_idx][8*b+:8] <= req_i.wdata[8*b+:8];
          end
        end
        rdata_q <= '0;
      end else begin
        rdata_q <= mem_q[bank][word_idx];
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  // always ready
  assign resp_o.gnt    = req_i.req;
  assign resp_o.rvalid = rvalid_q;
  assign resp_o.err    = 1'b0;
  assign resp_o.rdata  = rdata_q;

endmodule

/* rtl/ao_peripheral.sv */
// ####################
// always-on registers: exit valid, exit value,
// boot select readback and scratch
// ####################
`timescale 1ns/100ps

module ao_peripheral
  import mini_mcu_pkg::*;
(
  input  logic        clk_i,
  input  logic        arst_n_i,

  input  bus_req_t    req_i,
  output bus_resp_t   resp_o,

  input  logic        boot_select_i,
  output logic        exit_valid_o,
  output logic [31:0] exit_value_o
);

  logic [PERIPH_OFFSET_W-1:0] offset;
  logic                       exit_valid_q;
  logic [31:0]                exit_value_q;
  logic [31:0]                scratch_q;
  logic [31:0]                read_data;
  logic [31:0]                rdata_q;
  logic                       rvalid_q;

  assign offset = req_i.addr[PERIPH_OFFSET_W-1:0];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
      scratch_q    <= '0;
      rvalid_q     <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
      if (req_i.req && req_i.we) begin
        case (offset)
          AO_EXIT_VALID_OFFSET: begin
            if (req_i.be[0]) begin
              exit_valid_q <= req_i.wdata[0];
            end
          end
          AO_EXIT_VALUE_OFFSET: exit_value_q <= apply_be(exit_value_q, req_i.wdata, req_i.be);
          AO_SCRATCH_OFFSET:    scratch_q <= apply_be(scratch_q, req_i.wdata, req_i.be);
          default: ;
        endcase
      end
    end
  end

  // unused offsets read as zero
  always_comb begin
    case (offset)
      AO_EXIT_VALID_OFFSET:  read_data = {31'b0, exit_valid_q};
      AO_EXIT_VALUE_OFFSET:  read_data = exit_value_q;
      AO_BOOT_SELECT_OFFSET: read_data = {31'b0, boot_select_i};
      AO_SCRATCH_OFFSET:     read_data = scratch_q;
      default:               read_data = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= req_i.we ? '0 : read_data;
    end
  end

  assign resp_o.gnt    = req_i.req;
  assign resp_o.rvalid = rvalid_q;
  assign resp_o.err    = 1'b0;
  assign resp_o.rdata  = rdata_q;

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule

/* rtl/gpio_peripheral.sv */
// ####################
// GPIO out and enable registers
// and input synchroniser
// ####################
`timescale 1ns/100ps

module gpio_peripheral
  import mini_mcu_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,

  input  bus_req_t              req_i,
  output bus_resp_t             resp_o,

  input  logic [GPIO_WIDTH-1:0] gpio_i,
  output logic [GPIO_WIDTH-1:0] gpio_o,
  output logic [GPIO_WIDTH-1:0] gpio_en_o
);

  logic [PERIPH_OFFSET_W-1:0] offset;
  logic [GPIO_WIDTH-1:0]      gpio_meta_q;
  logic [GPIO_WIDTH-1:0]      gpio_sync_q;
  logic [GPIO_WIDTH-1:0]      gpio_out_q;
  logic [GPIO_WIDTH-1:0]      gpio_en_q;
  logic [31:0]                read_data;
  logic [31:0]                rdata_q;
  logic                       rvalid_q;

  assign offset = req_i.addr[PERIPH_OFFSET_W-1:0];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gpio_meta_q <= '0;
      gpio_sync_q <= '0;
      gpio_out_q  <= '0;
      gpio_en_q   <= '0;
      rvalid_q    <= 1'b0;
    end else begin
      // two flops before the pins are visible to software
      gpio_meta_q <= gpio_i;
      gpio_sync_q <= gpio_meta_q;
      rvalid_q    <= req_i.req;
      if (req_i.req && req_i.we) begin
        case (offset)
          GPIO_OUT_OFFSET: gpio_out_q <= apply_be(gpio_out_q, req_i.wdata, req_i.be);
          GPIO_EN_OFFSET:  gpio_en_q <= apply_be(gpio_en_q, req_i.wdata, req_i.be);
          // GPIO_IN is read only
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (offset)
      GPIO_IN_OFFSET:  read_data = gpio_sync_q;
      GPIO_OUT_OFFSET: read_data = gpio_out_q;
      GPIO_EN_OFFSET:  read_data = gpio_en_q;
      default:         read_data = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= req_i.we ? '0 : read_data;
    end
  end

  assign resp_o.gnt    = req_i.req;
  assign resp_o.rvalid = rvalid_q;
  assign resp_o.err    = 1'b0;
  assign resp_o.rdata  = rdata_q;

  assign gpio_o    = gpio_out_q;
  assign gpio_en_o = gpio_en_q;

endmodule

/* rtl/mini_mcu.sv */
// ####################
// top level: system bus, RAM,
// always-on and GPIO peripherals
// ####################
`timescale 1ns/100ps

module mini_mcu
  import mini_mcu_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        arst_n_i,

  // external masters in place of the core ports
  input  bus_req_t  [NUM_MASTERS-1:0] ext_master_req_i,
  output bus_resp_t [NUM_MASTERS-1:0] ext_master_resp_o,

  input  logic                        boot_select_i,
  output logic                        exit_valid_o,
  output logic [31:0]                 exit_value_o,

  input  logic [GPIO_WIDTH-1:0]       gpio_i,
  output logic [GPIO_WIDTH-1:0]       gpio_o,
  output logic [GPIO_WIDTH-1:0]       gpio_en_o
);

  bus_req_t  ram_slave_req;
  bus_resp_t ram_slave_resp;
  bus_req_t  ao_slave_req;
  bus_resp_t ao_slave_resp;
  bus_req_t  gpio_slave_req;
  bus_resp_t gpio_slave_resp;

  system_bus system_bus_i (
    .clk_i,
    .arst_n_i,
    .master_req_i (ext_master_req_i),
    .master_resp_o(ext_master_resp_o),
    .ram_req_o    (ram_slave_req),
    .ram_resp_i   (ram_slave_resp),
    .ao_req_o     (ao_slave_req),
    .ao_resp_i    (ao_slave_resp),
    .gpio_req_o   (gpio_slave_req),
    .gpio_resp_i  (gpio_slave_resp)
  );

  memory_subsystem memory_subsystem_i (
    .clk_i,
    .arst_n_i,
    .req_i (ram_slave_req),
    .resp_o(ram_slave_resp)
  );

  ao_peripheral ao_peripheral_i (
    .clk_i,
    .arst_n_i,
    .req_i (ao_slave_req),
    .resp_o(ao_slave_resp),
    .boot_select_i,
    .exit_valid_o,
    .exit_value_o
  );

  gpio_peripheral gpio_peripheral_i (
    .clk_i,
    .arst_n_i,
    .req_i (gpio_slave_req),
    .resp_o(gpio_slave_resp),
    .gpio_i,
    .gpio_o,
    .gpio_en_o
  );

endmodule

/* dv/tb_clk_gen.sv */
// ####################
// clock and reset for the testbench
// ####################
`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  localparam int HALF_PERIOD_NS = 10;
  localparam int RESET_CYCLES = 10;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD_NS clk_o = ~clk_o;
  end

  // release away from the rising edge
  initial begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

/* dv/tb_mini_mcu.sv */
// ####################
// testbench for mini_mcu: bus operations from the stim file
// on both masters, checks of responses and pins
// ####################
`timescale 1ns/100ps

module tb_mini_mcu;
  import mini_mcu_pkg::*;

  localparam int TIMEOUT_CYCLES = 20;
  localparam string STIM_FILE = "dv/mini_mcu_stim.txt";

  logic                        clk;
  logic                        arst_n;
  bus_req_t  [NUM_MASTERS-1:0] ext_req;
  bus_resp_t [NUM_MASTERS-1:0] ext_resp;
  logic                        boot_select;
  logic                        exit_valid;
  logic [31:0]                 exit_value;
  logic [GPIO_WIDTH-1:0]       gpio_in;
  logic [GPIO_WIDTH-1:0]       gpio_out;
  logic [GPIO_WIDTH-1:0]       gpio_en;

  // expected pin state
  logic                        exp_exit_valid;
  logic [31:0]                 exp_exit_value;
  logic [GPIO_WIDTH-1:0]       exp_gpio_out;
  logic [GPIO_WIDTH-1:0]       exp_gpio_en;
  logic [GPIO_WIDTH-1:0]       gpio_driven[$];
  logic [MASTER_IDX_W-1:0]     last_winner;

  tb_clk_gen clk_gen_i (
    .clk_o   (clk),
    .arst_n_o(arst_n)
  );

  mini_mcu dut_i (
    .clk_i            (clk),
    .arst_n_i         (arst_n),
    .ext_master_req_i (ext_req),
    .ext_master_resp_o(ext_resp),
    .boot_select_i    (boot_select),
    .exit_valid_o     (exit_valid),
    .exit_value_o     (exit_value),
    .gpio_i           (gpio_in),
    .gpio_o           (gpio_out),
    .gpio_en_o        (gpio_en)
  );

  task automatic stop_on_error();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  be);
    logic [31:0] res;
    for (int b = 0; b < 4; b++) begin
      res[8*b+:8] = be[b] ? new_word[8*b+:8] : old_word[8*b+:8];
    end
    return res;
  endfunction

  function automatic bus_req_t build_req(input logic we, input logic [31:0] addr,
                                         input logic [31:0] wdata, input logic [3:0] be);
    bus_req_t r;
    r.req   = 1'b1;
    r.we    = we;
    r.be    = be;
    r.addr  = addr;
    r.wdata = wdata;
    return r;
  endfunction

  // register writes land at the end of the accept cycle
  task automatic update_model(input logic we, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [3:0] be);
    if (we) begin
      case (addr)
        AO_START_ADDRESS + 32'(AO_EXIT_VALID_OFFSET): begin
          if (be[0]) begin
            exp_exit_valid = wdata[0];
          end
        end
        AO_START_ADDRESS + 32'(AO_EXIT_VALUE_OFFSET):
          exp_exit_value = merge_bytes(exp_exit_value, wdata, be);
        GPIO_START_ADDRESS + 32'(GPIO_OUT_OFFSET):
          exp_gpio_out = merge_bytes(exp_gpio_out, wdata, be);
        GPIO_START_ADDRESS + 32'(GPIO_EN_OFFSET):
          exp_gpio_en = merge_bytes(exp_gpio_en, wdata, be);
        default: ;
      endcase
    end
  endtask

  task automatic check_pins();
    assert (exit_valid == exp_exit_valid && exit_value == exp_exit_value &&
            gpio_out == exp_gpio_out && gpio_en == exp_gpio_en) else begin
      $display("FAILED at %0t: pins exit_valid=%0b exit_value=%h gpio_o=%h gpio_en_o=%h",
               $time, exit_valid, exit_value, gpio_out, gpio_en);
      $display("  expected %0b %h %h %h", exp_exit_valid, exp_exit_value,
               exp_gpio_out, exp_gpio_en);
      stop_on_error();
    end
  endtask

  task automatic wait_grant(input logic [MASTER_IDX_W-1:0] m);
    int cycles;
    cycles = 0;
    #1;
    while (!ext_resp[m].gnt) begin
      if (cycles == TIMEOUT_CYCLES) begin
        $display("master %0d was never granted", m);
        stop_on_error();
      end
      @(negedge clk);
      #1;
      cycles++;
    end
    assert (!ext_resp[~m].gnt) else begin
      $display("FAILED at %0t: both masters granted in the same cycle", $time);
      stop_on_error();
    end
    last_winner = m;
  endtask

  // drop req right after the accept edge, then expect rvalid one cycle on
  task automatic finish_op(input logic [MASTER_IDX_W-1:0] m, input logic we,
                           input logic [31:0] exp_rdata, input logic exp_err);
    int cycles;
    @(negedge clk);
    ext_req[m] = '0;
    cycles = 1;
    while (!ext_resp[m].rvalid) begin
      if (cycles == TIMEOUT_CYCLES) begin
        $display("master %0d never got a response", m);
        stop_on_error();
      end
      @(negedge clk);
      cycles++;
    end
    assert (cycles == 1) else begin
      $display("FAILED at %0t: master %0d rvalid %0d cycles after grant", $time, m, cycles);
      stop_on_error();
    end
    assert (!ext_resp[~m].rvalid) else begin
      $display("FAILED at %0t: response for master %0d also reached the other master",
               $time, m);
      stop_on_error();
    end
    assert (ext_resp[m].err == exp_err) else begin
      $display("FAILED at %0t: master %0d err=%0b, expected %0b", $time, m,
               ext_resp[m].err, exp_err);
      stop_on_error();
    end
    if (!we || exp_err) begin
      assert (ext_resp[m].rdata == exp_rdata) else begin
        $display("FAILED at %0t: master %0d rdata=%h, expected %h", $time, m,
                 ext_resp[m].rdata, exp_rdata);
        stop_on_error();
      end
    end
    check_pins();
  endtask

  task automatic run_single(input logic [MASTER_IDX_W-1:0] m, input int op,
                            input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] be, input logic [31:0] exp_rdata,
                            input logic exp_err);
    logic [31:0] expect_data;
    expect_data = exp_rdata;
    if (op == 2) begin
      // new pin value, then give the synchroniser time
      gpio_in = $urandom();
      gpio_driven.push_back(gpio_in);
      repeat (3) @(negedge clk);
      expect_data = gpio_driven[$];
    end
    ext_req[m] = build_req(op == 1, addr, wdata, be);
    wait_grant(m);
    if (!exp_err) begin
      update_model(op == 1, addr, wdata, be);
    end
    finish_op(m, op == 1, expect_data, exp_err);
  endtask

  task automatic run_tie(input int op, input logic [31:0] addr, input logic [31:0] wdata,
                         input logic [3:0] be, input logic [31:0] exp_rdata,
                         input logic exp_err);
    logic [MASTER_IDX_W-1:0] win;
    logic [MASTER_IDX_W-1:0] lose;
    win = ~last_winner;
    lose = last_winner;
    ext_req[0] = build_req(op == 1, addr, wdata, be);
    ext_req[1] = build_req(op == 1, addr, wdata, be);
    #1;
    assert (ext_resp[win].gnt && !ext_resp[lose].gnt) else begin
      $display("FAILED at %0t: tie not granted to master %0d", $time, win);
      stop_on_error();
    end
    wait_grant(win);
    if (!exp_err) begin
      update_model(op == 1, addr, wdata, be);
    end
    finish_op(win, op == 1, exp_rdata, exp_err);
    wait_grant(lose);
    finish_op(lose, op == 1, exp_rdata, exp_err);
  endtask

  initial begin
    int          fd;
    int          n;
    int          waited;
    int          num_ops;
    int          m_int;
    int          op;
    int          err_int;
    string       line;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] exp_rdata;
    logic [3:0]  be;

    void'($urandom(32'h078d98a2));
    ext_req = '0;
    boot_select = 1'b1;
    gpio_in = '0;
    exp_exit_valid = 1'b0;
    exp_exit_value = '0;
    exp_gpio_out = '0;
    exp_gpio_en = '0;
    last_winner = '0;
    num_ops = 0;

    waited = 0;
    while (arst_n !== 1'b1) begin
      if (waited == 50) begin
        $display("reset was never released");
        stop_on_error();
      end
      @(negedge clk);
      waited++;
    end
    @(negedge clk);
    assert (exit_valid == 1'b0 && exit_value == '0 && gpio_out == '0 && gpio_en == '0 &&
            !ext_resp[0].gnt && !ext_resp[1].gnt &&
            !ext_resp[0].rvalid && !ext_resp[1].rvalid) else begin
      $display("FAILED at %0t: outputs not idle after reset", $time);
      stop_on_error();
    end

    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("cannot open stimulus file %s", STIM_FILE);
      stop_on_error();
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%d %d %h %h %h %h %d", m_int, op, addr, wdata, be, exp_rdata,
                  err_int);
      if (n != 7) begin
        $display("malformed stimulus line: %s", line);
        stop_on_error();
      end
      if (m_int == 2) begin
        run_tie(op, addr, wdata, be, exp_rdata, err_int != 0);
      end else begin
        run_single(MASTER_IDX_W'(m_int), op, addr, wdata, be, exp_rdata, err_int != 0);
      end
      num_ops++;
    end
    $fclose(fd);

    if (num_ops == 0) begin
      $display("stimulus file held no operations");
      stop_on_error();
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

/* dv/mini_mcu_stim.txt */
# master (0, 1, 2 = both) op (0 read, 1 write, 2 read GPIO_IN after random gpio_i)
# addr wdata be exp_rdata in hex, exp_err 0 or 1
2 0 2000000C 00000000 0 00000000 0
# RAM bank 0, partial byte enables
0 1 00000010 11223344 f 00000000 0
1 1 00000010 AABBCCDD 5 00000000 0
1 0 00000010 00000000 0 11BB33DD 0
# RAM bank 1
0 1 00000414 CAFEF00D f 00000000 0
0 1 00000414 12345678 a 00000000 0
0 0 00000414 00000000 0 12FE560D 0
1 0 00000414 00000000 0 12FE560D 0
2 0 00000010 00000000 0 11BB33DD 0
# exit value, exit valid, boot select
0 1 20000004 DEADBEEF f 00000000 0
1 1 20000000 00000001 1 00000000 0
0 0 20000000 00000000 0 00000001 0
1 0 20000004 00000000 0 DEADBEEF 0
0 0 20000008 00000000 0 00000001 0
# GPIO out, enable and input
1 1 30000004 A5A5F00F f 00000000 0
0 1 30000008 FFFF00FF 3 00000000 0
1 0 30000008 00000000 0 000000FF 0
0 2 30000000 00000000 0 00000000 0
1 2 30000000 00000000 0 00000000 0
1 1 30000000 FFFFFFFF f 00000000 0
2 1 2000000C 5A5A5A5A f 00000000 0
0 0 2000000C 00000000 0 5A5A5A5A 0
# unmapped accesses
0 1 40000000 01020304 f BADCAB1E 1
0 0 40000000 00000000 0 BADCAB1E 1
2 0 40000010 00000000 0 BADCAB1E 1
0 0 00000010 00000000 0 11BB33DD 0
1 0 2000000C 00000000 0 5A5A5A5A 0
0 0 20000010 00000000 0 00000000 0

/* compile.f */
rtl/mini_mcu_pkg.sv
rtl/system_bus.sv
rtl/memory_subsystem.sv
rtl/ao_peripheral.sv
rtl/gpio_peripheral.sv
rtl/mini_mcu.sv
dv/tb_clk_gen.sv
dv/tb_mini_mcu.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the mini_mcu testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f compile.f --top-module tb_mini_mcu \
  -o tb_mini_mcu \
  && ./obj_dir/tb_mini_mcu 2>&1 | tee sim.log \
  || { echo "build or simulation failed"; exit 1; }

grep -q "^Result: PASSED$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
